// File: project.f
boot_pkg.sv
spart.sv
boot_loader.sv
instr_mem.sv
boot_subsys.sv
tb_boot.sv

// File: run.sh
#!/bin/sh
# compile and run the boot loader testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps \
        -f project.f --top-module tb_boot --Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_boot 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// File: tb_boot.sv
`timescale 1ns/100ps

module tb_boot;

    localparam int         CLK_PERIOD   = 100;
    localparam int         RESET_CYCLES = 16;
    localparam int         NUM_LOADS    = 3;
    localparam logic [7:0] CHAR_BOOT    = 8'h42;
    localparam logic [7:0] CHAR_COUNT   = 8'h49;
    localparam logic [7:0] CHAR_ACK     = 8'h41;
    localparam logic [7:0] CHAR_DONE    = 8'h43;

    logic        clk;
    logic        rst_n;
    logic        rx_valid_i;
    logic [7:0]  rx_data_i;
    logic        rx_ready_o;
    logic        tx_valid_o;
    logic [7:0]  tx_data_o;
    logic        tx_ready_i;
    logic        cpu_stall_o;
    logic [13:0] fetch_addr_i;
    logic [31:0] fetch_data_o;

    logic [31:0] rng_state;
    logic [7:0]  rx_stream [$];    // count bytes then instruction bytes, lsb first
    logic [7:0]  tx_expect [$];
    logic [31:0] word_expect [$];
    int          cycle_count;
    int          cycle_limit;
    int          load_idx;
    logic        load_active;
    logic        done_seen;        // 'C' has reached the tx register

    boot_subsys dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_valid_i   (rx_valid_i),
        .rx_data_i    (rx_data_i),
        .rx_ready_o   (rx_ready_o),
        .tx_valid_o   (tx_valid_o),
        .tx_data_o    (tx_data_o),
        .tx_ready_i   (tx_ready_i),
        .cpu_stall_o  (cpu_stall_o),
        .fetch_addr_i (fetch_addr_i),
        .fetch_data_o (fetch_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // stall stays high until 'C' is loaded for transmit, low from the next cycle on
    always @(negedge clk) begin
        if (!load_active) begin
            done_seen <= 1'b0;
        end else begin
            check_value(32'(cpu_stall_o), 32'(!done_seen), "cpu_stall_o");
            if (tx_valid_o && tx_data_o == CHAR_DONE)
                done_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!load_active) begin
            cycle_count <= 0;
        end else if (cycle_count >= cycle_limit) begin
            $display("timeout: load %0d still running after %0d cycles", load_idx, cycle_count);
            $display("sim failed");
            $fatal(1);
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // host side of the receive link, valid held until the fifo takes the byte
    task automatic send_rx_bytes();
        int          idx;
        int          gap;
        logic        taken;
        logic [31:0] r;

        idx   = 0;
        gap   = 0;
        taken = 1'b0;
        while (idx < rx_stream.size()) begin
            @(posedge clk);
            if (taken) begin
                idx++;
                r   = next_random();
                gap = (r[2:0] < 3'd5) ? 0 : int'(r[4:3]) + 1;    // mostly bursts
            end
            if (idx < rx_stream.size() && gap == 0) begin
                rx_valid_i <= 1'b1;
                rx_data_i  <= rx_stream[idx];
            end else begin
                rx_valid_i <= 1'b0;
                if (gap > 0)
                    gap--;
            end
            @(negedge clk);
            taken = rx_valid_i && rx_ready_o;
        end
    endtask

    task automatic collect_tx_bytes();
        int          seen;
        int          stall;
        logic [31:0] r;

        seen  = 0;
        stall = 0;
        while (seen < tx_expect.size()) begin
            @(posedge clk);
            if (stall > 0) begin
                tx_ready_i <= 1'b0;
                stall--;
            end else begin
                tx_ready_i <= 1'b1;
            end
            @(negedge clk);
            if (tx_valid_o && tx_ready_i) begin
                check_value(32'(tx_data_o), 32'(tx_expect[seen]),
                            $sformatf("tx byte %0d", seen));
                seen++;
                r     = next_random();
                stall = (r[1:0] == 2'd0) ? int'(r[4:2] % 3'd6) : 0;    // up to five
            end
        end
    endtask

    task automatic run_load();
        int          n;
        int          wait_cycles;
        logic [31:0] w;

        n = int'(next_random() % 32'd12) + 1;
        rx_stream.delete();
        tx_expect.delete();
        word_expect.delete();
        for (int i = 0; i < 4; i++)
            rx_stream.push_back(8'(n >> (8 * i)));
        for (int i = 0; i < n; i++) begin
            w = next_random();
            word_expect.push_back(w);
            for (int b = 0; b < 4; b++)
                rx_stream.push_back(w[8*b +: 8]);
        end
        tx_expect.push_back(CHAR_BOOT);
        repeat (3) tx_expect.push_back(CHAR_COUNT);
        repeat (4 * n - 1) tx_expect.push_back(CHAR_ACK);    // none after the last byte
        tx_expect.push_back(CHAR_DONE);
        cycle_limit = 40 * (rx_stream.size() + tx_expect.size()) + 500;

        @(posedge clk);
        rst_n        <= 1'b0;
        rx_valid_i   <= 1'b0;
        tx_ready_i   <= 1'b0;
        fetch_addr_i <= '0;
        load_active  <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value(32'(tx_valid_o), 32'd0, "tx_valid_o in reset");
        check_value(32'(rx_ready_o), 32'd1, "rx_ready_o in reset");
        check_value(32'(dut_i.imem_wr_strb), 32'd0, "imem strobes in reset");
        check_value(32'(dut_i.bus_read), 32'd0, "bus read in reset");
        @(posedge clk);
        rst_n <= 1'b1;

        // 'B' is expected within two cycles of release
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!tx_valid_o && wait_cycles < 2);
        check_value(32'(tx_valid_o), 32'd1, "tx_valid_o after reset release");
        check_value(32'(tx_data_o), 32'(CHAR_BOOT), "first tx byte");

        fork
            send_rx_bytes();
            collect_tx_bytes();
        join

        repeat (8) begin
            @(negedge clk);
            check_value(32'(tx_valid_o), 32'd0, "tx_valid_o after load");
        end
        check_value(32'(dut_i.u_spart.rx_count), 32'd0, "rx fifo level after load");

        for (int a = 0; a < n; a++) begin
            @(posedge clk);
            fetch_addr_i <= 14'(a);
            @(posedge clk);
            @(negedge clk);
            check_value(fetch_data_o, word_expect[a], $sformatf("fetch word %0d", a));
        end
        @(posedge clk);
        load_active <= 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        rx_valid_i   = 1'b0;
        rx_data_i    = '0;
        tx_ready_i   = 1'b0;
        fetch_addr_i = '0;
        rng_state    = 32'd95981;
        cycle_limit  = 500;
        load_idx     = 0;
        load_active  = 1'b0;
        for (int i = 0; i < NUM_LOADS; i++) begin
            load_idx = i;
            run_load();
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: boot_subsys.sv
`timescale 1ns/100ps

module boot_subsys (
    input  logic                 clk,
    input  logic                 rst_n,

    // host serial bytes
    input  logic                 rx_valid_i,
    input  boot_pkg::byte_t      rx_data_i,
    output logic                 rx_ready_o,
    output logic                 tx_valid_o,
    output boot_pkg::byte_t      tx_data_o,
    input  logic                 tx_ready_i,

    // processor side
    output logic                 cpu_stall_o,
    input  boot_pkg::imem_addr_t fetch_addr_i,
    output boot_pkg::word_t      fetch_data_o
);

    // loader to spart bus
    logic                  bus_write;
    logic                  bus_read;
    boot_pkg::bus_addr_t   bus_addr;
    boot_pkg::word_t       bus_wdata;
    boot_pkg::word_t       bus_rdata;
    logic                  bus_ack;

    // loader to memory
    logic [3:0]            imem_wr_strb;
    boot_pkg::imem_addr_t  imem_wr_addr;
    boot_pkg::word_t       imem_wr_data;

    spart u_spart (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_write_i (bus_write),
        .bus_read_i  (bus_read),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata),
        .bus_ack_o   (bus_ack),
        .rx_valid_i  (rx_valid_i),
        .rx_data_i   (rx_data_i),
        .rx_ready_o  (rx_ready_o),
        .tx_valid_o  (tx_valid_o),
        .tx_data_o   (tx_data_o),
        .tx_ready_i  (tx_ready_i)
    );

    boot_loader u_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus_write_o    (bus_write),
        .bus_read_o     (bus_read),
        .bus_addr_o     (bus_addr),
        .bus_wdata_o    (bus_wdata),
        .bus_rdata_i    (bus_rdata),
        .bus_ack_i      (bus_ack),
        .imem_wr_strb_o (imem_wr_strb),
        .imem_wr_addr_o (imem_wr_addr),
        .imem_wr_data_o (imem_wr_data),
        .cpu_stall_o    (cpu_stall_o)
    );

    instr_mem u_imem (
        .clk          (clk),
        .wr_strb_i    (imem_wr_strb),
        .wr_addr_i    (imem_wr_addr),
        .wr_data_i    (imem_wr_data),
        .fetch_addr_i (fetch_addr_i),
        .fetch_data_o (fetch_data_o)
    );

endmodule

// File: instr_mem.sv
`timescale 1ns/100ps

module instr_mem (
    input  logic                 clk,

    // loader write port
    input  logic [3:0]           wr_strb_i,
    input  boot_pkg::imem_addr_t wr_addr_i,
    input  boot_pkg::word_t      wr_data_i,

    // processor fetch port
    input  boot_pkg::imem_addr_t fetch_addr_i,
    output boot_pkg::word_t      fetch_data_o
);

    boot_pkg::word_t mem [2**boot_pkg::IMEM_ADDR_W];

    boot_pkg::word_t fetch_q;

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_strb_i[i])
                mem[wr_addr_i][i*8 +: 8] <= wr_data_i[i*8 +: 8];
        end
    end

    // data valid one cycle after the address
    always_ff @(posedge clk) begin
        fetch_q <= mem[fetch_addr_i];
    end

    assign fetch_data_o = fetch_q;

endmodule

// File: boot_loader.sv
`timescale 1ns/100ps

module boot_loader (
    input  logic                 clk,
    input  logic                 rst_n,

    // bus master towards the spart
    output logic                 bus_write_o,
    output logic                 bus_read_o,
    output boot_pkg::bus_addr_t  bus_addr_o,
    output boot_pkg::word_t      bus_wdata_o,
    input  boot_pkg::word_t      bus_rdata_i,
    input  logic                 bus_ack_i,

    // instruction memory write port
    output logic [3:0]           imem_wr_strb_o,
    output boot_pkg::imem_addr_t imem_wr_addr_o,
    output boot_pkg::word_t      imem_wr_data_o,

    output logic                 cpu_stall_o
);

    boot_pkg::loader_state_t state;
    boot_pkg::loader_state_t next_state;

    logic [1:0]            byte_cnt;      // byte within count or instruction
    boot_pkg::word_t       instr_count;   // number of words to load
    boot_pkg::word_t       rx_words;      // words written so far
    boot_pkg::word_t       rx_words_inc;
    boot_pkg::imem_addr_t  wr_addr;
    boot_pkg::byte_t       instr_b0;
    boot_pkg::byte_t       instr_b1;
    boot_pkg::byte_t       instr_b2;
    boot_pkg::byte_t       rx_byte;

    logic inc_byte;
    logic wr_count;
    logic wr_instr;
    logic word_done;

    assign rx_byte      = bus_rdata_i[7:0];
    assign rx_words_inc = rx_words + 32'd1;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= boot_pkg::SEND_BOOT;
        else
            state <= next_state;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            byte_cnt <= 2'd0;
        else if (inc_byte)
            byte_cnt <= byte_cnt + 2'd1;    // wraps after the fourth byte
    end

    // count arrives lsb first
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            instr_count <= '0;
        else if (wr_count)
            instr_count[byte_cnt*8 +: 8] <= rx_byte;
    end

    // lower three bytes of the word under assembly
    always_ff @(posedge clk) begin
        if (wr_instr) begin
            case (byte_cnt)
                2'd0:    instr_b0 <= rx_byte;
                2'd1:    instr_b1 <= rx_byte;
                2'd2:    instr_b2 <= rx_byte;
                default: ;    // top byte goes straight to memory
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_addr  <= '0;
            rx_words <= '0;
        end else if (word_done) begin
            wr_addr  <= wr_addr + boot_pkg::IMEM_ADDR_W'(1);
            rx_words <= rx_words_inc;
        end
    end

    always_comb begin
        next_state  = state;
        inc_byte    = 1'b0;
        wr_count    = 1'b0;
        wr_instr    = 1'b0;
        word_done   = 1'b0;
        bus_write_o = 1'b0;
        bus_read_o  = 1'b0;
        bus_addr_o  = '0;
        bus_wdata_o = '0;

        case (state)
            boot_pkg::SEND_BOOT: begin
                bus_write_o = 1'b1;
                bus_addr_o  = boot_pkg::SPART_TX_ADDR;
                bus_wdata_o = boot_pkg::word_t'(boot_pkg::CH_BOOT);
                if (bus_ack_i)
                    next_state = boot_pkg::READ_COUNT;
            end

            boot_pkg::READ_COUNT: begin
                bus_read_o = 1'b1;
                bus_addr_o = boot_pkg::SPART_RX_ADDR;
                if (bus_ack_i) begin
                    wr_count = 1'b1;
                    inc_byte = 1'b1;
                    if (byte_cnt == 2'd3)
                        next_state = boot_pkg::READ_INSTR;    // no 'I' after last count byte
                    else
                        next_state = boot_pkg::SEND_COUNT_ACK;
                end
            end

            boot_pkg::SEND_COUNT_ACK: begin
                bus_write_o = 1'b1;
                bus_addr_o  = boot_pkg::SPART_TX_ADDR;
                bus_wdata_o = boot_pkg::word_t'(boot_pkg::CH_COUNT);
                if (bus_ack_i)
                    next_state = boot_pkg::READ_COUNT;
            end

            boot_pkg::READ_INSTR: begin
                bus_read_o = 1'b1;
                bus_addr_o = boot_pkg::SPART_RX_ADDR;
                if (bus_ack_i) begin
                    wr_instr   = 1'b1;
                    inc_byte   = 1'b1;
                    next_state = boot_pkg::SEND_INSTR_ACK;
                    if (byte_cnt == 2'd3) begin
                        word_done = 1'b1;
                        // last byte of the last word gets 'C' instead of 'A'
                        if (rx_words_inc == instr_count)
                            next_state = boot_pkg::SEND_DONE;
                    end
                end
            end

            boot_pkg::SEND_INSTR_ACK: begin
                bus_write_o = 1'b1;
                bus_addr_o  = boot_pkg::SPART_TX_ADDR;
                bus_wdata_o = boot_pkg::word_t'(boot_pkg::CH_ACK);
                if (bus_ack_i)
                    next_state = boot_pkg::READ_INSTR;
            end

            boot_pkg::SEND_DONE: begin
                bus_write_o = 1'b1;
                bus_addr_o  = boot_pkg::SPART_TX_ADDR;
                bus_wdata_o = boot_pkg::word_t'(boot_pkg::CH_DONE);
                if (bus_ack_i)
                    next_state = boot_pkg::RUN;
            end

            default: begin
                next_state = boot_pkg::RUN;    // stays here until reset
            end
        endcase
    end

    // word is written in the ack cycle of its fourth byte
    assign imem_wr_strb_o = word_done ? 4'b1111 : 4'b0000;
    assign imem_wr_addr_o = wr_addr;
    assign imem_wr_data_o = {rx_byte, instr_b2, instr_b1, instr_b0};
    assign cpu_stall_o    = (state != boot_pkg::RUN);

endmodule

// File: spart.sv
`timescale 1ns/100ps

module spart (
    input  logic                clk,
    input  logic                rst_n,

    // bus slave
    input  logic                bus_write_i,
    input  logic                bus_read_i,
    input  boot_pkg::bus_addr_t bus_addr_i,
    input  boot_pkg::word_t     bus_wdata_i,
    output boot_pkg::word_t     bus_rdata_o,
    output logic                bus_ack_o,

    // deserialized receive side
    input  logic                rx_valid_i,
    input  boot_pkg::byte_t     rx_data_i,
    output logic                rx_ready_o,

    // transmit side
    output logic                tx_valid_o,
    output boot_pkg::byte_t     tx_data_o,
    input  logic                tx_ready_i
);

    boot_pkg::byte_t                 rx_fifo [boot_pkg::RX_FIFO_DEPTH];
    logic [boot_pkg::RX_PTR_W-1:0]   rx_wr_ptr;
    logic [boot_pkg::RX_PTR_W-1:0]   rx_rd_ptr;
    logic [boot_pkg::RX_CNT_W-1:0]   rx_count;
    logic                            rx_push;
    logic                            rx_pop;
    logic                            rx_empty;

    boot_pkg::byte_t                 tx_hold;
    logic                            tx_full;
    logic                            tx_load;

    boot_pkg::byte_t                 rdata_q;
    logic                            ack_q;
    logic                            rd_req;
    logic                            wr_req;

    // no new request is taken while the previous ack is still out
    assign rd_req = bus_read_i && (bus_addr_i == boot_pkg::SPART_RX_ADDR) && !ack_q;
    assign wr_req = bus_write_i && (bus_addr_i == boot_pkg::SPART_TX_ADDR) && !ack_q;

    assign rx_empty   = (rx_count == '0);
    assign rx_ready_o = (rx_count != boot_pkg::RX_CNT_W'(boot_pkg::RX_FIFO_DEPTH));
    assign rx_push    = rx_valid_i && rx_ready_o;
    assign rx_pop     = rd_req && !rx_empty;    // read waits here for data
    assign tx_load    = wr_req && !tx_full;     // write waits here for room

    // fifo storage
    always_ff @(posedge clk) begin
        if (rx_push)
            rx_fifo[rx_wr_ptr] <= rx_data_i;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
        end else begin
            if (rx_push)
                rx_wr_ptr <= rx_wr_ptr + boot_pkg::RX_PTR_W'(1);
            if (rx_pop)
                rx_rd_ptr <= rx_rd_ptr + boot_pkg::RX_PTR_W'(1);
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            rx_count <= '0;
        else if (rx_push && !rx_pop)
            rx_count <= rx_count + boot_pkg::RX_CNT_W'(1);
        else if (rx_pop && !rx_push)
            rx_count <= rx_count - boot_pkg::RX_CNT_W'(1);
    end

    // popped byte is presented together with the ack
    always_ff @(posedge clk) begin
        if (rx_pop)
            rdata_q <= rx_fifo[rx_rd_ptr];
        if (tx_load)
            tx_hold <= bus_wdata_i[7:0];
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            tx_full <= 1'b0;
        else if (tx_load)
            tx_full <= 1'b1;
        else if (tx_full && tx_ready_i)
            tx_full <= 1'b0;    // byte taken by the serializer
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= rx_pop || tx_load;    // one cycle pulse
    end

    assign bus_ack_o   = ack_q;
    assign bus_rdata_o = boot_pkg::word_t'(rdata_q);
    assign tx_valid_o  = tx_full;
    assign tx_data_o   = tx_hold;

endmodule

// File: boot_pkg.sv
package boot_pkg;

    // memory geometry
    localparam int IMEM_ADDR_W = 14;

    // receive fifo sizing
    localparam int RX_FIFO_DEPTH = 4;
    localparam int RX_PTR_W      = $clog2(RX_FIFO_DEPTH);
    localparam int RX_CNT_W      = $clog2(RX_FIFO_DEPTH + 1);  // must hold the full count

    typedef logic [31:0]            word_t;
    typedef logic [31:0]            bus_addr_t;
    typedef logic [7:0]             byte_t;
    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

    // spart register map
    localparam bus_addr_t SPART_TX_ADDR = 32'h4000_001C;
    localparam bus_addr_t SPART_RX_ADDR = SPART_TX_ADDR + 32'd1;

    // characters sent back to the host
    localparam byte_t CH_BOOT  = 8'h42;  // 'B'
    localparam byte_t CH_COUNT = 8'h49;  // 'I'
    localparam byte_t CH_ACK   = 8'h41;  // 'A'
    localparam byte_t CH_DONE  = 8'h43;  // 'C'

    typedef enum logic [2:0] {
        SEND_BOOT,
        READ_COUNT,
        SEND_COUNT_ACK,
        READ_INSTR,
        SEND_INSTR_ACK,
        SEND_DONE,
        RUN
    } loader_state_t;

endpackage
